// File: led_pkg.sv
`default_nettype none

package led_pkg;

    // AHB-Lite bus fields
    typedef logic [31:0] haddr_t;
    typedef logic [31:0] hdata_t;
    typedef logic [1:0]  htrans_t;
    typedef logic [2:0]  hsize_t;
    typedef logic [2:0]  hburst_t;

    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam hsize_t  HSIZE_WORD    = 3'b010;  // 32-bit transfer
    localparam hburst_t HBURST_SINGLE = 3'b000;

    localparam logic hresp_okay  = 1'b0;
    localparam logic hresp_error = 1'b1;

    // pins and nibbles, both active low
    typedef logic [7:0] gpio_t;
    typedef logic [3:0] led_t;   // 0 = lit
    typedef logic [3:0] key_t;   // 0 = pressed

    // gpio register map, byte offsets
    localparam haddr_t OFFSET_DATA_RO = 32'h0000_0000;
    localparam haddr_t OFFSET_DATA    = 32'h0000_0004;
    localparam haddr_t OFFSET_DIRM    = 32'h0000_0008;
    localparam haddr_t OFFSET_OEN     = 32'h0000_000C;

    // upper nibble outputs, leds dark
    localparam gpio_t GPIO_INIT = 8'hF0;

    typedef enum logic [2:0] {
        MODE_NONE,
        MODE_CHASE,
        MODE_FAST,
        MODE_HEART,
        MODE_BREATHE
    } led_mode_t;

    typedef enum logic [2:0] {
        CFG_DIRM,
        CFG_OEN,
        CFG_DATA,
        RUN_READ,
        RUN_WRITE
    } cu_state_t;

    // one pattern frame, kept short for simulation
    localparam int FRAME_LEN  = 1024;
    localparam int FRAME_BITS = 10;

    typedef logic [FRAME_BITS-1:0] frame_t;

endpackage

`default_nettype wire

// File: ahb_gpio.sv
`timescale 1ns/10ps
`default_nettype none

module ahb_gpio
    import led_pkg::*;
(
    input  wire logic    iHCLK,
    input  wire logic    iHRESETn,
    input  wire haddr_t  haddr,
    input  wire htrans_t htrans,
    input  wire logic    hwrite,
    input  wire hsize_t  hsize,
    input  wire hdata_t  hwdata,
    output hdata_t       hrdata,
    output logic         hready,
    output logic         hresp,
    input  wire key_t    keys,
    output gpio_t        gpio_out,
    output gpio_t        gpio_oe
);

    // captured address phase
    logic       ap_valid;
    logic       ap_write;
    logic       ap_bad_size;
    logic [3:0] ap_off;

    gpio_t data_q;
    gpio_t dirm_q;
    gpio_t oen_q;
    key_t  key_q;    // key pins registered once before the bus sees them
    gpio_t pin_in;
    gpio_t pins;
    gpio_t rd_sel;

    assign hready = 1'b1;   // zero-wait slave

    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            ap_valid    <= 1'b0;
            ap_write    <= 1'b0;
            ap_bad_size <= 1'b0;
            ap_off      <= '0;
        end else if (hready) begin
            ap_valid    <= htrans[1];   // NONSEQ or SEQ
            ap_write    <= hwrite;
            ap_bad_size <= (hsize != HSIZE_WORD);
            ap_off      <= haddr[3:0];
        end
    end

    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            key_q <= '1;
        end else begin
            key_q <= keys;
        end
    end

    // register writes land at the end of the data phase
    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            data_q <= '0;
            dirm_q <= '0;
            oen_q  <= '0;
        end else if (ap_valid && ap_write && !ap_bad_size) begin
            case (ap_off)
                OFFSET_DATA[3:0]: data_q <= hwdata[7:0];
                OFFSET_DIRM[3:0]: dirm_q <= hwdata[7:0];
                OFFSET_OEN[3:0]:  oen_q  <= hwdata[7:0];
                default: ;                          // DATA_RO is read only
            endcase
        end
    end

    // undriven led pins read high
    assign pin_in = {4'hF, key_q};
    assign pins   = (dirm_q & data_q) | (~dirm_q & pin_in);

    always_comb begin
        case (ap_off)
            OFFSET_DATA_RO[3:0]: rd_sel = pins;
            OFFSET_DATA[3:0]:    rd_sel = data_q;
            OFFSET_DIRM[3:0]:    rd_sel = dirm_q;
            OFFSET_OEN[3:0]:     rd_sel = oen_q;
            default:             rd_sel = '0;
        endcase
    end

    assign hrdata = {{24{1'b0}}, rd_sel};
    assign hresp  = (ap_valid && ap_bad_size) ? hresp_error : hresp_okay;

    assign gpio_out = data_q & dirm_q;
    assign gpio_oe  = oen_q & dirm_q;

    // the master only ever issues word transfers
    a_word_only: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        htrans[1] |-> (hsize == HSIZE_WORD));

endmodule

`default_nettype wire

// File: led_pattern_gen.sv
`timescale 1ns/10ps
`default_nettype none

module led_pattern_gen
    import led_pkg::*;
(
    input  wire logic      iHCLK,
    input  wire logic      iHRESETn,
    input  wire led_mode_t mode,
    output led_t           led
);

    frame_t     timer_q;
    logic [1:0] quarter;
    logic [2:0] eighth;
    logic [3:0] sixteenth;
    logic [2:0] breathe_k;
    frame_t     breathe_mask;
    logic       breathe_on;
    logic       heart_on;

    // free-running frame timer
    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            timer_q <= '0;
        end else if (timer_q == frame_t'(FRAME_LEN - 1)) begin
            timer_q <= '0;
        end else begin
            timer_q <= timer_q + 1'b1;
        end
    end

    assign quarter   = timer_q[FRAME_BITS-1 -: 2];
    assign eighth    = timer_q[FRAME_BITS-1 -: 3];
    assign sixteenth = timer_q[FRAME_BITS-1 -: 4];

    // pulses in sixteenths 13 and 15
    assign heart_on = (sixteenth == 4'd13) || (sixteenth == 4'd15);

    // k per eighth, duty goes up then back down
    always_comb begin
        case (eighth)
            3'd0:    breathe_k = 3'd6;
            3'd1:    breathe_k = 3'd5;
            3'd2:    breathe_k = 3'd4;
            3'd3:    breathe_k = 3'd3;
            3'd4:    breathe_k = 3'd2;
            3'd5:    breathe_k = 3'd3;
            3'd6:    breathe_k = 3'd4;
            default: breathe_k = 3'd5;
        endcase
    end

    assign breathe_mask = ~({FRAME_BITS{1'b1}} << breathe_k);   // low k bits set
    assign breathe_on   = (timer_q & breathe_mask) == '0;

    always_comb begin
        case (mode)
            MODE_CHASE:   led = ~(4'b0001 << quarter);
            MODE_FAST:    led = ~(4'b0001 << eighth[1:0]);   // two laps per frame
            MODE_HEART:   led = heart_on ? 4'b0000 : 4'b1111;
            MODE_BREATHE: led = breathe_on ? 4'b0000 : 4'b1111;
            default:      led = 4'b1111;                      // all dark
        endcase
    end

endmodule

`default_nettype wire

// File: led_control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module led_control_unit
    import led_pkg::*;
(
    input  wire logic   iHCLK,
    input  wire logic   iHRESETn,
    input  wire logic   hready,
    input  wire logic   hresp,
    input  wire hdata_t hrdata,
    output haddr_t      haddr,
    output htrans_t     htrans,
    output logic        hwrite,
    output hsize_t      hsize,
    output hburst_t     hburst,
    output hdata_t      hwdata,
    output led_mode_t   mode,
    input  wire led_t   led
);

    cu_state_t state;        // transfer now in its address phase
    cu_state_t state_succ;
    cu_state_t state_nxt;
    haddr_t    addr_nxt;

    // pending data phase
    logic      dp_valid;
    cu_state_t dp_state;

    key_t      key;

    assign hsize  = HSIZE_WORD;
    assign hburst = HBURST_SINGLE;

    always_comb begin
        case (state)
            CFG_DIRM:  state_succ = CFG_OEN;
            CFG_OEN:   state_succ = CFG_DATA;
            CFG_DATA:  state_succ = RUN_READ;
            RUN_READ:  state_succ = RUN_WRITE;
            RUN_WRITE: state_succ = RUN_READ;
            default:   state_succ = CFG_DIRM;
        endcase
    end

    // first accepted edge out of reset just starts the DIRM write
    assign state_nxt = (htrans == HTRANS_IDLE) ? state : state_succ;

    always_comb begin
        case (state_nxt)
            CFG_DIRM: addr_nxt = OFFSET_DIRM;
            CFG_OEN:  addr_nxt = OFFSET_OEN;
            CFG_DATA: addr_nxt = OFFSET_DATA;
            RUN_READ: addr_nxt = OFFSET_DATA_RO;
            default:  addr_nxt = OFFSET_DATA;
        endcase
    end

    // address phase, held while hready is low
    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            state  <= CFG_DIRM;
            htrans <= HTRANS_IDLE;
            haddr  <= '0;
            hwrite <= 1'b0;
        end else if (hready) begin
            state  <= state_nxt;
            htrans <= HTRANS_NONSEQ;
            haddr  <= addr_nxt;
            hwrite <= (state_nxt != RUN_READ);
        end
    end

    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            dp_valid <= 1'b0;
            dp_state <= CFG_DIRM;
        end else if (hready) begin
            dp_valid <= (htrans == HTRANS_NONSEQ);
            dp_state <= state;
        end
    end

    // led nibble goes out on bits 7:4
    always_comb begin
        hwdata = '0;
        if (dp_valid) begin
            case (dp_state)
                RUN_WRITE: hwdata = {{24{1'b0}}, led, 4'b0000};
                RUN_READ:  hwdata = '0;
                default:   hwdata = {{24{1'b0}}, GPIO_INIT};
            endcase
        end
    end

    assign key = hrdata[3:0];

    // mode register, decoded when the read completes
    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            mode <= MODE_NONE;
        end else if (hready) begin
            if (htrans == HTRANS_NONSEQ && state == CFG_DATA) begin
                mode <= MODE_CHASE;          // default once configured
            end else if (dp_valid && dp_state == RUN_READ) begin
                case (key)
                    4'b1110: mode <= MODE_CHASE;
                    4'b1101: mode <= MODE_FAST;
                    4'b1011: mode <= MODE_HEART;
                    4'b0111: mode <= MODE_BREATHE;
                    default: ;               // released or chord, keep mode
                endcase
            end
        end
    end

    a_hold_addr: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        (htrans != HTRANS_IDLE && !hready) |=>
            ($stable(haddr) && $stable(htrans) && $stable(hwrite)));

    a_mode_set: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        (htrans == HTRANS_NONSEQ && (state == RUN_READ || state == RUN_WRITE))
            |-> (mode != MODE_NONE));

    // slave only errors on non-word sizes
    a_no_error: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        dp_valid |-> (hresp == hresp_okay));

endmodule

`default_nettype wire

// File: led_gpio_top.sv
`timescale 1ns/10ps
`default_nettype none

module led_gpio_top
    import led_pkg::*;
(
    input  wire logic iHCLK,
    input  wire logic iHRESETn,
    input  wire key_t keys,
    output gpio_t     gpio_out,
    output gpio_t     gpio_oe
);

    haddr_t    haddr;
    htrans_t   htrans;
    logic      hwrite;
    hsize_t    hsize;
    hdata_t    hwdata;
    hdata_t    hrdata;
    logic      hready;
    logic      hresp;
    led_mode_t mode;
    led_t      led;

    led_control_unit i_led_control_unit (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .hready   (hready),
        .hresp    (hresp),
        .hrdata   (hrdata),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hsize    (hsize),
        .hburst   (),           // single transfers only, slave has no burst input
        .hwdata   (hwdata),
        .mode     (mode),
        .led      (led)
    );

    led_pattern_gen i_led_pattern_gen (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .mode     (mode),
        .led      (led)
    );

    ahb_gpio i_ahb_gpio (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hsize    (hsize),
        .hwdata   (hwdata),
        .hrdata   (hrdata),
        .hready   (hready),
        .hresp    (hresp),
        .keys     (keys),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic iHCLK,
    output logic por_n
);

    localparam int HALF_PERIOD  = 4;   // 8 ns clock
    localparam int RESET_CYCLES = 8;

    initial begin
        iHCLK = 1'b0;
        forever #(HALF_PERIOD) iHCLK = ~iHCLK;
    end

    // power-on reset, let go on a falling edge
    initial begin
        por_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge iHCLK);
        por_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_led_gpio.sv
`timescale 1ns/10ps
`default_nettype none

module tb_led_gpio
    import led_pkg::*;
();

    localparam int NROWS     = 11;
    localparam int MAX_EXTRA = 16;      // random slack after each row
    localparam int SEED      = 56;
    localparam int BREATHE_K [8] = '{6, 5, 4, 3, 2, 3, 4, 5};

    logic  iHCLK;
    logic  por_n;
    logic  run_rst_n;
    logic  iHRESETn;
    key_t  keys;
    gpio_t gpio_out;
    gpio_t gpio_oe;

    // stimulus table, one row per step
    string     row_name  [NROWS];
    key_t      row_keys  [NROWS];
    int        row_hold  [NROWS];
    led_mode_t row_mode  [NROWS];
    logic      row_reset [NROWS];
    logic      table_ready;

    // reference model
    int        cyc;         // rising edges since reset release
    key_t      m_key_q;
    led_mode_t m_mode;
    led_t      m_led;
    gpio_t     exp_out;
    gpio_t     exp_oe;

    int checks;
    int errors;

    assign iHRESETn = por_n & run_rst_n;

    tb_clock_gen i_tb_clock_gen (
        .iHCLK (iHCLK),
        .por_n (por_n)
    );

    led_gpio_top i_led_gpio_top (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .keys     (keys),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    function automatic led_t one_lit(int idx);
        case (idx)
            0:       return 4'b1110;
            1:       return 4'b1101;
            2:       return 4'b1011;
            default: return 4'b0111;
        endcase
    endfunction

    // LED nibble for a mode at frame position t
    function automatic led_t expected_led(led_mode_t md, int t);
        int   pos;
        int   k;
        led_t lit;
        pos = t % FRAME_LEN;
        lit = 4'b1111;
        case (md)
            MODE_CHASE: lit = one_lit(pos / (FRAME_LEN / 4));
            MODE_FAST:  lit = one_lit((pos / (FRAME_LEN / 8)) % 4);
            MODE_HEART: begin
                if (pos / (FRAME_LEN / 16) == 13 || pos / (FRAME_LEN / 16) == 15) begin
                    lit = 4'b0000;
                end
            end
            MODE_BREATHE: begin
                k = BREATHE_K[pos / (FRAME_LEN / 8)];
                if (pos % (1 << k) == 0) begin
                    lit = 4'b0000;
                end
            end
            default: lit = 4'b1111;
        endcase
        return lit;
    endfunction

    function automatic led_mode_t decode_keys(key_t k, led_mode_t cur);
        case (k)
            4'b1110: return MODE_CHASE;
            4'b1101: return MODE_FAST;
            4'b1011: return MODE_HEART;
            4'b0111: return MODE_BREATHE;
            default: return cur;            // released or chord
        endcase
    endfunction

    // config writes finish on edges 3..5, reads on even edges, writes on odd
    always @(posedge iHCLK) begin
        if (!iHRESETn) begin
            cyc     = 0;
            m_key_q = 4'hF;
            m_mode  = MODE_NONE;
            m_led   = 4'hF;
            exp_out = '0;
            exp_oe  = '0;
        end else begin
            cyc = cyc + 1;
            if (cyc == 4) begin
                exp_oe = GPIO_INIT;
                m_mode = MODE_CHASE;
            end
            if (cyc == 5) begin
                exp_out = GPIO_INIT;
            end
            if (cyc >= 6 && cyc % 2 == 0) begin
                m_mode = decode_keys(m_key_q, m_mode);
            end
            if (cyc >= 7 && cyc % 2 == 1) begin
                m_led   = expected_led(m_mode, cyc - 1);   // led of the data phase
                exp_out = {m_led, 4'h0};
            end
            m_key_q = keys;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    // compare pins against the model once per cycle
    task automatic run_cycles(input string name, input int n);
        repeat (n) begin
            @(negedge iHCLK);
            check_value({name, " gpio_out"}, 32'(exp_out), 32'(gpio_out));
            check_value({name, " gpio_oe"}, 32'(exp_oe), 32'(gpio_oe));
        end
    endtask

    task automatic check_config(input string name);
        check_value({name, " config oe"}, 32'(GPIO_INIT), 32'(gpio_oe));
        check_value({name, " config low pins"}, 32'h0, 32'(gpio_out[3:0]));
    endtask

    task automatic set_row(input int i, input string name, input key_t k, input int hold,
                           input led_mode_t md, input logic rst);
        row_name[i]  = name;
        row_keys[i]  = k;
        row_hold[i]  = hold;
        row_mode[i]  = md;
        row_reset[i] = rst;
    endtask

    task automatic load_table();
        set_row(0,  "idle_chase",     4'b1111, FRAME_LEN, MODE_CHASE,   1'b0);
        set_row(1,  "key1_fast",      4'b1101, FRAME_LEN, MODE_FAST,    1'b0);
        set_row(2,  "release_fast",   4'b1111, FRAME_LEN, MODE_FAST,    1'b0);
        set_row(3,  "key2_heart",     4'b1011, FRAME_LEN, MODE_HEART,   1'b0);
        set_row(4,  "chord_heart",    4'b1001, FRAME_LEN, MODE_HEART,   1'b0);
        set_row(5,  "key3_breathe",   4'b0111, FRAME_LEN, MODE_BREATHE, 1'b0);
        set_row(6,  "chord_breathe",  4'b0011, FRAME_LEN, MODE_BREATHE, 1'b0);
        set_row(7,  "key0_chase",     4'b1110, FRAME_LEN, MODE_CHASE,   1'b0);
        set_row(8,  "key1_fast_again", 4'b1101, FRAME_LEN, MODE_FAST,   1'b0);
        set_row(9,  "reset_midrun",   4'b1111, FRAME_LEN, MODE_CHASE,   1'b1);
        set_row(10, "heart_after_rst", 4'b1011, FRAME_LEN, MODE_HEART,  1'b0);
    endtask

    function automatic int watchdog_cycles();
        int sum;
        sum = 2 * FRAME_LEN + NROWS * MAX_EXTRA;
        for (int i = 0; i < NROWS; i++) begin
            sum += row_hold[i];
        end
        return sum;
    endfunction

    initial begin
        int extra;
        void'($urandom(SEED));
        keys        = 4'hF;
        run_rst_n   = 1'b1;
        checks      = 0;
        errors      = 0;
        table_ready = 1'b0;
        load_table();
        table_ready = 1'b1;

        wait (por_n === 1'b1);
        run_cycles("config", 6);
        check_config("config");

        for (int i = 0; i < NROWS; i++) begin
            extra = int'($urandom % MAX_EXTRA);
            keys  = row_keys[i];
            if (row_reset[i]) begin
                run_rst_n = 1'b0;
                run_cycles({row_name[i], " in reset"}, 8);
                run_rst_n = 1'b1;
                run_cycles(row_name[i], 6);
                check_config(row_name[i]);
                run_cycles(row_name[i], row_hold[i] + extra - 14);
            end else begin
                run_cycles(row_name[i], row_hold[i] + extra);
            end
            check_value({row_name[i], " mode"}, 32'(row_mode[i]),
                        32'(i_led_gpio_top.mode));
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        int limit;
        wait (table_ready === 1'b1);
        limit = watchdog_cycles();
        repeat (limit) @(posedge iHCLK);
        $display("timed out: the run did not end within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
led_pkg.sv
ahb_gpio.sv
led_pattern_gen.sv
led_control_unit.sv
led_gpio_top.sv
tb_clock_gen.sv
tb_led_gpio.sv

// File: run_sim.sh
#!/bin/sh
# build and run the LED sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_led_gpio -f list.f -o sim_led_gpio

./obj_dir/sim_led_gpio | tee sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
